/* logic/match_pkg.sv */
package match_pkg;

    // window and compare geometry
    localparam int ADDR_WIDTH     = 10;  // 1024-byte window
    localparam int MATCH_WIDTH    = 4;   // bytes per beat
    localparam int BURST_LEN      = 4;   // beats per burst
    localparam int MAX_MATCH_LEN  = 64;
    localparam int MATCH_LEN_BITS = 7;
    localparam int TAG_BITS       = 8;

    // scoreboard
    localparam int SB_DEPTH    = 2;
    localparam int SB_IDX_BITS = 1;

    // derived sizes
    localparam int BURST_BYTES   = MATCH_WIDTH * BURST_LEN;   // address step per burst
    localparam int BEAT_LEN_BITS = $clog2(MATCH_WIDTH + 1);   // holds 0..MATCH_WIDTH

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [MATCH_WIDTH*8-1:0]   word_t;      // lowest byte in bits 7:0
    typedef logic [MATCH_LEN_BITS-1:0]  len_t;
    typedef logic [BEAT_LEN_BITS-1:0]   beat_len_t;
    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [SB_IDX_BITS-1:0]     idx_t;

    typedef struct packed {
        tag_t  tag;
        addr_t head_addr;
        addr_t history_addr;
    } match_req_t;

    typedef struct packed {
        tag_t tag;
        len_t match_len;
    } match_resp_t;

    typedef struct packed {
        addr_t addr;    // address of the lowest byte
        word_t data;
    } buf_write_t;

    typedef struct packed {
        idx_t  idx;
        logic  last;    // final beat of the burst
        addr_t head_addr;
        addr_t history_addr;
    } pipe_issue_t;

    typedef struct packed {
        idx_t      idx;
        logic      last;
        beat_len_t match_len;
    } pipe_result_t;

endpackage

/* logic/history_buffer.sv */
`timescale 1ns/100ps

module history_buffer (
    input  logic                  clk,
    input  logic                  i_wr_en,
    input  match_pkg::buf_write_t i_wr,
    input  match_pkg::addr_t      i_rd_head_addr,
    input  match_pkg::addr_t      i_rd_hist_addr,
    output match_pkg::word_t      o_rd_head_data,
    output match_pkg::word_t      o_rd_hist_data
);

    // one byte per address, so a word can start anywhere in the window
    logic [7:0] mem [2**match_pkg::ADDR_WIDTH];

    // write lanes, each byte lands at its own address
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int k = 0; k < match_pkg::MATCH_WIDTH; k++) begin
                // address sum is ADDR_WIDTH bits wide and wraps at the window end
                mem[i_wr.addr + match_pkg::addr_t'(k)] <= i_wr.data[k*8 +: 8];
            end
        end
    end

    // two independent read ports, one cycle latency
    always_ff @(posedge clk) begin
        for (int k = 0; k < match_pkg::MATCH_WIDTH; k++) begin
            o_rd_head_data[k*8 +: 8] <= mem[i_rd_head_addr + match_pkg::addr_t'(k)];
            o_rd_hist_data[k*8 +: 8] <= mem[i_rd_hist_addr + match_pkg::addr_t'(k)];
        end
    end

endmodule

/* logic/match_pipeline.sv */
`timescale 1ns/100ps

module match_pipeline (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_issue_valid,
    input  match_pkg::pipe_issue_t  i_issue,
    output match_pkg::addr_t        o_rd_head_addr,
    output match_pkg::addr_t        o_rd_hist_addr,
    input  match_pkg::word_t        i_rd_head_data,
    input  match_pkg::word_t        i_rd_hist_data,
    output logic                    o_result_valid,
    output match_pkg::pipe_result_t o_result
);

    // stage 1, issued beat
    logic                   s1_valid;
    match_pkg::pipe_issue_t s1_issue;

    // stage 2, sideband next to the buffer read registers
    logic                   s2_valid;
    match_pkg::idx_t        s2_idx;
    logic                   s2_last;

    // compare of the words returned for stage 2
    match_pkg::beat_len_t   eq_len;
    logic                   eq_run;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            s1_valid       <= i_issue_valid;
            s2_valid       <= s1_valid;
            o_result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_issue <= i_issue;
        s2_idx   <= s1_issue.idx;   // travels with the read in flight
        s2_last  <= s1_issue.last;
    end

    assign o_rd_head_addr = s1_issue.head_addr;
    assign o_rd_hist_addr = s1_issue.history_addr;

    // leading equal bytes, lowest byte first, stop at the first difference
    always_comb begin
        eq_len = '0;
        eq_run = 1'b1;
        for (int k = 0; k < match_pkg::MATCH_WIDTH; k++) begin
            if (eq_run && i_rd_head_data[k*8 +: 8] == i_rd_hist_data[k*8 +: 8]) begin
                eq_len = eq_len + match_pkg::beat_len_t'(1);
            end else begin
                eq_run = 1'b0;
            end
        end
    end

    // stage 3 result register
    always_ff @(posedge clk) begin
        o_result.idx       <= s2_idx;
        o_result.last      <= s2_last;
        o_result.match_len <= eq_len;
    end

endmodule

/* logic/match_scoreboard.sv */
`timescale 1ns/100ps

module match_scoreboard (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_req_valid,
    output logic                    o_req_ready,
    input  match_pkg::match_req_t   i_req,
    output logic                    o_resp_valid,
    input  logic                    i_resp_ready,
    output match_pkg::match_resp_t  o_resp,
    output logic                    o_issue_valid,
    output match_pkg::pipe_issue_t  o_issue,
    input  logic                    i_result_valid,
    input  match_pkg::pipe_result_t i_result
);

    // entry flags
    logic [match_pkg::SB_DEPTH-1:0] sb_occ;    // entry holds a request
    logic [match_pkg::SB_DEPTH-1:0] sb_wait;   // next burst not yet issued
    logic [match_pkg::SB_DEPTH-1:0] sb_done;   // response pending
    logic [match_pkg::SB_DEPTH-1:0] sb_contd;  // all beats so far were full

    // entry payload, bases advance by one burst per round
    match_pkg::match_req_t sb_req [match_pkg::SB_DEPTH];
    match_pkg::len_t       sb_len [match_pkg::SB_DEPTH];

    match_pkg::idx_t  first_free;
    match_pkg::idx_t  first_done;
    match_pkg::idx_t  alloc_idx;
    logic             req_fire;
    logic             resp_fire;

    // burst issue state
    match_pkg::idx_t  issue_idx;
    match_pkg::idx_t  next_issue_idx;
    match_pkg::addr_t issue_offset;
    logic             issue_last;

    // result decode, one result per cycle at most
    logic [match_pkg::SB_DEPTH-1:0] res_hit;
    match_pkg::len_t  res_sum;
    logic             res_full;
    logic             res_finish;

    // lowest free and lowest done entry
    always_comb begin
        first_free = '0;
        first_done = '0;
        for (int i = match_pkg::SB_DEPTH - 1; i >= 0; i--) begin
            if (!sb_occ[i]) begin
                first_free = match_pkg::idx_t'(i);
            end
            if (sb_done[i]) begin
                first_done = match_pkg::idx_t'(i);
            end
        end
    end

    assign next_issue_idx = issue_idx + match_pkg::idx_t'(1);

    // prefer the entry that issues next, else the first free one
    assign alloc_idx = sb_occ[next_issue_idx] ? first_free : next_issue_idx;

    assign o_req_ready  = ~&sb_occ;
    assign o_resp_valid = |sb_done;
    assign req_fire     = i_req_valid & o_req_ready;
    assign resp_fire    = o_resp_valid & i_resp_ready;

    assign o_resp = '{tag: sb_req[first_done].tag, match_len: sb_len[first_done]};

    // beat offset within the burst
    assign issue_last =
        (issue_offset == match_pkg::addr_t'(match_pkg::BURST_BYTES - match_pkg::MATCH_WIDTH));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_idx    <= '0;
            issue_offset <= '0;
        end else if (!sb_wait[issue_idx] || issue_last) begin
            issue_idx    <= next_issue_idx;   // idle entry skipped in one cycle
            issue_offset <= '0;
        end else begin
            issue_offset <= issue_offset + match_pkg::addr_t'(match_pkg::MATCH_WIDTH);
        end
    end

    assign o_issue_valid = sb_wait[issue_idx];

    always_comb begin
        o_issue.idx          = issue_idx;
        o_issue.last         = issue_last;
        o_issue.head_addr    = sb_req[issue_idx].head_addr + issue_offset;
        o_issue.history_addr = sb_req[issue_idx].history_addr + issue_offset;
    end

    // results only count for a live entry
    always_comb begin
        for (int i = 0; i < match_pkg::SB_DEPTH; i++) begin
            res_hit[i] = i_result_valid && i_result.idx == match_pkg::idx_t'(i) &&
                         sb_occ[i] && !sb_done[i];
        end
    end

    assign res_sum  = sb_len[i_result.idx] + match_pkg::len_t'(i_result.match_len);
    assign res_full = (i_result.match_len == match_pkg::beat_len_t'(match_pkg::MATCH_WIDTH));

    // stop on a break, a short final beat or the length cap
    assign res_finish = !sb_contd[i_result.idx] || !res_full ||
                        (res_sum >= match_pkg::len_t'(match_pkg::MAX_MATCH_LEN));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb_occ   <= '0;
            sb_wait  <= '0;
            sb_done  <= '0;
            sb_contd <= '0;
        end else begin
            for (int i = 0; i < match_pkg::SB_DEPTH; i++) begin
                if (req_fire && alloc_idx == match_pkg::idx_t'(i)) begin
                    sb_occ[i]   <= 1'b1;
                    sb_wait[i]  <= 1'b1;
                    sb_contd[i] <= 1'b1;
                end else begin
                    if (o_issue_valid && issue_last && issue_idx == match_pkg::idx_t'(i)) begin
                        sb_wait[i] <= 1'b0;   // whole burst is in the pipeline
                    end
                    if (res_hit[i]) begin
                        if (!res_full) begin
                            sb_contd[i] <= 1'b0;   // later beats get dropped
                        end
                        if (i_result.last) begin
                            if (res_finish) begin
                                sb_done[i] <= 1'b1;
                            end else begin
                                sb_wait[i] <= 1'b1;   // another burst
                            end
                        end
                    end
                    if (resp_fire && first_done == match_pkg::idx_t'(i)) begin
                        sb_done[i] <= 1'b0;
                        sb_occ[i]  <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < match_pkg::SB_DEPTH; i++) begin
            if (req_fire && alloc_idx == match_pkg::idx_t'(i)) begin
                sb_req[i] <= i_req;
                sb_len[i] <= '0;
            end else if (res_hit[i]) begin
                if (sb_contd[i]) begin
                    sb_len[i] <= res_sum;
                end
                if (i_result.last && !res_finish) begin
                    sb_req[i].head_addr <=
                        sb_req[i].head_addr + match_pkg::addr_t'(match_pkg::BURST_BYTES);
                    sb_req[i].history_addr <=
                        sb_req[i].history_addr + match_pkg::addr_t'(match_pkg::BURST_BYTES);
                end
            end
        end
    end

endmodule

/* logic/match_engine_top.sv */
`timescale 1ns/100ps

module match_engine_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    input  match_pkg::match_req_t  i_req,
    output logic                   o_resp_valid,
    input  logic                   i_resp_ready,
    output match_pkg::match_resp_t o_resp,
    input  logic                   i_wr_en,
    input  match_pkg::buf_write_t  i_wr
);

    // scoreboard to pipeline
    logic                    issue_valid;
    match_pkg::pipe_issue_t  issue;
    logic                    result_valid;
    match_pkg::pipe_result_t result;

    // pipeline to buffer
    match_pkg::addr_t        rd_head_addr;
    match_pkg::addr_t        rd_hist_addr;
    match_pkg::word_t        rd_head_data;
    match_pkg::word_t        rd_hist_data;

    match_scoreboard match_scoreboard_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req          (i_req),
        .o_resp_valid   (o_resp_valid),
        .i_resp_ready   (i_resp_ready),
        .o_resp         (o_resp),
        .o_issue_valid  (issue_valid),
        .o_issue        (issue),
        .i_result_valid (result_valid),
        .i_result       (result)
    );

    match_pipeline match_pipeline_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_issue_valid  (issue_valid),
        .i_issue        (issue),
        .o_rd_head_addr (rd_head_addr),
        .o_rd_hist_addr (rd_hist_addr),
        .i_rd_head_data (rd_head_data),
        .i_rd_hist_data (rd_hist_data),
        .o_result_valid (result_valid),
        .o_result       (result)
    );

    history_buffer history_buffer_inst (
        .clk            (clk),
        .i_wr_en        (i_wr_en),
        .i_wr           (i_wr),
        .i_rd_head_addr (rd_head_addr),
        .i_rd_hist_addr (rd_hist_addr),
        .o_rd_head_data (rd_head_data),
        .o_rd_hist_data (rd_hist_data)
    );

endmodule

/* sim/clk_rst_gen.sv */
`timescale 1ns/100ps

module clk_rst_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // low for 8 rising edges, released just after the last one
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* sim/match_engine_tb.sv */
`timescale 1ns/100ps

module match_engine_tb;

    localparam int WIN    = 2**match_pkg::ADDR_WIDTH;
    localparam int N_REQ  = 50;
    localparam int REQ_CYCLES = N_REQ * (match_pkg::MAX_MATCH_LEN / match_pkg::MATCH_WIDTH
                                         + 2 * match_pkg::BURST_LEN + 8);
    localparam int WR_CYCLES  = 2 * (WIN / match_pkg::MATCH_WIDTH) + N_REQ * 130;

    logic                   clk;
    logic                   rst_n;
    logic                   i_req_valid;
    logic                   o_req_ready;
    match_pkg::match_req_t  i_req;
    logic                   o_resp_valid;
    logic                   i_resp_ready;
    match_pkg::match_resp_t o_resp;
    logic                   i_wr_en;
    match_pkg::buf_write_t  i_wr;

    logic [7:0] win [WIN];        // mirror of the history window
    int         exp_len [256];    // indexed by tag
    bit         outstanding [256];
    int         out_cnt = 0;
    int         next_tag = 0;
    int         ready_mode = 1;   // 0 low, 1 high, 2 random
    int         seed = 32'hcc9d;
    int         ready_seed = 32'hcc9d;
    logic                   hold_prev;
    match_pkg::match_resp_t resp_prev;

    clk_rst_gen clk_rst_gen_inst (.clk(clk), .rst_n(rst_n));

    match_engine_top match_engine_top_inst (
        .clk(clk), .rst_n(rst_n),
        .i_req_valid(i_req_valid), .o_req_ready(o_req_ready), .i_req(i_req),
        .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready), .o_resp(o_resp),
        .i_wr_en(i_wr_en), .i_wr(i_wr)
    );

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "testbench stopped");
    endtask

    // forward walk with wrap, stops at the cap
    function automatic int model_len(int head, int hist);
        int n;
        n = 0;
        while (n < match_pkg::MAX_MATCH_LEN && win[(head + n) % WIN] == win[(hist + n) % WIN])
            n++;
        return n;
    endfunction

    // all driving tasks start and end 1 ns after a rising edge
    task automatic write_word(int addr, logic [31:0] data);
        i_wr_en   = 1'b1;
        i_wr.addr = match_pkg::addr_t'(addr % WIN);
        i_wr.data = data;
        for (int k = 0; k < match_pkg::MATCH_WIDTH; k++)
            win[(addr + k) % WIN] = data[k*8 +: 8];
        @(posedge clk);
        #1;
        i_wr_en = 1'b0;
    endtask

    task automatic write_byte(int addr, logic [7:0] b);
        write_word(addr, {win[(addr + 3) % WIN], win[(addr + 2) % WIN],
                          win[(addr + 1) % WIN], b});
    endtask

    // copy len bytes from head to hist, then force a difference
    task automatic plant_match(int head, int hist, int len);
        for (int i = 0; i < len; i++)
            write_byte(hist + i, win[(head + i) % WIN]);
        write_byte(hist + len, ~win[(head + len) % WIN]);
    endtask

    task automatic fill_window(bit rnd);
        logic [31:0] d;
        for (int a = 0; a < WIN; a += match_pkg::MATCH_WIDTH) begin
            for (int k = 0; k < 4; k++)
                d[k*8 +: 8] = 8'(((a + k) * 37) ^ (((a + k) >> 8) * 91));  // whole address
            if (rnd)
                d = $random(seed);
            write_word(a, d);
        end
    endtask

    task automatic send_req(int head, int hist);
        exp_len[next_tag]     = model_len(head, hist);
        outstanding[next_tag] = 1'b1;
        out_cnt++;
        i_req_valid = 1'b1;
        i_req = '{tag: match_pkg::tag_t'(next_tag), head_addr: match_pkg::addr_t'(head % WIN),
                  history_addr: match_pkg::addr_t'(hist % WIN)};
        next_tag++;
        do @(posedge clk); while (!o_req_ready);
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (out_cnt != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic directed(int head, int hist, int len);
        plant_match(head, hist, len);
        send_req(head, hist);
        wait_idle();
    endtask

    // response ready pattern
    initial begin
        i_resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (ready_mode == 2)
                i_resp_ready = ($random(ready_seed) % 4) != 0;
            else
                i_resp_ready = ready_mode == 1;
        end
    end

    // held response keeps valid asserted
    assert property (@(posedge clk) disable iff (!rst_n)
                     (o_resp_valid && !i_resp_ready) |=> o_resp_valid)
        else report_failure("response valid dropped before the response was taken");

    // response monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_prev) begin
                assert (o_resp == resp_prev)
                    else report_failure($sformatf("** Error o_resp: expected %h, actual %h",
                                                  resp_prev, o_resp));
            end
            hold_prev <= o_resp_valid && !i_resp_ready;
            resp_prev <= o_resp;
            if (o_resp_valid && i_resp_ready) begin
                assert (outstanding[o_resp.tag])
                    else report_failure($sformatf("response tag %h was not outstanding",
                                                  o_resp.tag));
                assert (int'(o_resp.match_len) == exp_len[o_resp.tag])
                    else report_failure($sformatf(
                        "** Error o_resp.match_len (tag %h): expected %h, actual %h",
                        o_resp.tag, exp_len[o_resp.tag], o_resp.match_len));
                outstanding[o_resp.tag] = 1'b0;
                out_cnt--;
            end
        end else begin
            hold_prev <= 1'b0;
        end
    end

    // watchdog
    initial begin
        repeat (REQ_CYCLES + WR_CYCLES + 100) @(posedge clk);
        $display("simulation timed out");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int h;
        int d;
        int h2;
        int d2;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_wr_en     = 1'b0;
        i_wr        = '0;
        for (int t = 0; t < 256; t++)
            outstanding[t] = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        assert (o_req_ready && !o_resp_valid)
            else report_failure("ready low or response valid right after reset");
        #1;

        fill_window(1'b0);
        directed(100, 400, 0);     // first byte differs
        directed(120, 440, 3);
        directed(140, 480, 9);     // later beat of the first burst
        directed(300, 820, 16);    // ends at a burst boundary
        directed(200, 700, 20);
        directed(230, 760, 37);    // third burst
        directed(980, 500, 70);    // head crosses the window end
        directed(600, 1010, 80);   // history crosses the window end

        // both entries busy, no response taken
        ready_mode = 0;
        plant_match(150, 860, 5);
        plant_match(170, 900, 26);
        send_req(150, 860);
        send_req(170, 900);
        repeat (40) begin
            @(posedge clk);
            assert (!o_req_ready) else report_failure("request ready high with both entries busy");
        end
        #1;
        ready_mode = 1;
        wait_idle();

        // seeded random sweep, two requests in flight
        fill_window(1'b1);
        ready_mode = 2;
        for (int it = 0; it < 20; it++) begin
            h  = $random(seed) & (WIN - 1);
            d  = $random(seed) & (WIN - 1);
            h2 = $random(seed) & (WIN - 1);
            d2 = $random(seed) & (WIN - 1);
            // window is written only while the engine is idle
            plant_match(h, d, $random(seed) & 127);
            plant_match(h2, d2, $random(seed) & 31);
            send_req(h, d);
            send_req(h2, d2);
            wait_idle();
        end

        if (!o_resp_valid && o_req_ready) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("engine not idle after the last response");
            $display("Checks failed");
            $fatal(1, "run ended with the engine busy");
        end
    end

endmodule

/* compile.f */
logic/match_pkg.sv
logic/history_buffer.sv
logic/match_pipeline.sv
logic/match_scoreboard.sv
logic/match_engine_top.sv
sim/clk_rst_gen.sv
sim/match_engine_tb.sv

/* Makefile */
# Verilator build of the match engine testbench

TOP := match_engine_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f compile.f

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
